/* src/noc_defs.svh */
`ifndef NOC_DEFS_SVH
`define NOC_DEFS_SVH

`define NOC_P 5    // router ports, local included
`define NOC_V 4    // vcs per port
`define NOC_C 2    // traffic classes

// slice [V*i +: V] of the C*V bits lists the vcs open to class i
// class 0 -> vc 0,1   class 1 -> vc 2,3
`define NOC_CLASS_SETTING 8'b1100_0011

`define NOC_CREDIT_DEPTH 4    // downstream buffer slots per vc

`endif

/* src/noc_flit_pkg.sv */
`include "noc_defs.svh"

package noc_flit_pkg;

    // packet header fields seen by the allocator

    localparam int CLASS_W = (`NOC_C > 1) ? $clog2(`NOC_C) : 1;
    localparam int DEST_W = `NOC_P - 1;    // local port excluded

    typedef logic [CLASS_W-1:0] class_t;
    typedef logic [DEST_W-1:0] dest_t;    // one-hot

endpackage

/* src/noc_vc_pkg.sv */
`include "noc_defs.svh"

package noc_vc_pkg;

    // output vc bookkeeping types

    localparam int VC_W = (`NOC_V > 1) ? $clog2(`NOC_V) : 1;
    localparam int CREDIT_W = $clog2(`NOC_CREDIT_DEPTH + 1);    // 0..depth

    typedef logic [`NOC_V-1:0] vc_mask_t;
    typedef logic [VC_W-1:0] vc_idx_t;
    typedef logic [CREDIT_W-1:0] credit_t;

    typedef enum logic {
        IDLE,
        ACTIVE
    } alloc_state_t;

endpackage

/* src/class_ovc_table.sv */
`timescale 1ns/1ps
`include "noc_defs.svh"

module class_ovc_table (
    input  noc_flit_pkg::class_t class_in,
    output noc_vc_pkg::vc_mask_t cand_mask
);

    import noc_vc_pkg::*;

    localparam int C = `NOC_C;
    localparam int V = `NOC_V;
    localparam int CVW = (C == 0) ? V : C * V;
    localparam logic [CVW-1:0] CLASS_SETTING = `NOC_CLASS_SETTING;

    generate
        if (C == 0 || C == 1) begin : g_no_class
            assign cand_mask = '1;    // single class owns every vc
        end else begin : g_class
            vc_mask_t class_table [C];

            for (genvar i = 0; i < C; i++) begin : g_slice
                assign class_table[i] = CLASS_SETTING[i*V +: V];
            end

            assign cand_mask = class_table[class_in];

            // class_in has to select a real row of the table
            always_comb begin
                a_class_range: assert ($isunknown(class_in) || int'(class_in) < C)
                    else $error("class_in %0d outside the class table", class_in);
            end
        end
    endgenerate

endmodule

/* src/ovc_arbiter.sv */
`timescale 1ns/1ps
`include "noc_defs.svh"

module ovc_arbiter (
    input  logic                 clk,
    input  logic                 rst_n,
    input  noc_vc_pkg::vc_mask_t eligible,
    input  noc_flit_pkg::dest_t  dest,
    input  logic                 advance,
    output noc_vc_pkg::vc_mask_t pick,
    output logic                 pick_valid
);

    import noc_vc_pkg::*;

    localparam int V = `NOC_V;
    localparam int P1 = `NOC_P - 1;
    localparam int OFFSET = (P1 > 0 && P1 < V) ? V / P1 : 0;

    vc_mask_t prio_init;
    vc_mask_t prio;
    vc_mask_t pref_hit;
    vc_mask_t pref_pick;
    vc_mask_t rr_pick;
    vc_idx_t  ptr;
    vc_idx_t  pick_idx;

    // destination port -> preferred vc
    generate
        if (P1 == V) begin : g_direct
            assign prio_init = dest;
        end else if (P1 > V) begin : g_fold
            for (genvar i = 0; i < V; i++) begin : g_or
                assign prio_init[i] = |dest[((i+1)*P1)/V-1 : (i*P1)/V];
            end
        end else begin : g_spread
            always_comb begin
                prio_init = '0;
                for (int j = 0; j < P1; j++) begin
                    prio_init[j+OFFSET] = dest[j];
                end
            end
        end
    endgenerate

    assign prio = (prio_init == '0) ? vc_mask_t'(1) : prio_init;    // fall back to vc 0
    assign pref_hit = eligible & prio;
    assign pref_pick = pref_hit & (~pref_hit + 1'b1);    // lowest set bit

    // first eligible vc after the pointer, wrapping
    always_comb begin
        int unsigned idx;
        logic found;
        rr_pick = '0;
        found = 1'b0;
        for (int k = 1; k <= V; k++) begin
            idx = (int'(ptr) + k) % V;
            if (!found && eligible[idx]) begin
                rr_pick[idx] = 1'b1;
                found = 1'b1;
            end
        end
    end

    assign pick = (pref_pick != '0) ? pref_pick : rr_pick;
    assign pick_valid = |eligible;

    always_comb begin
        pick_idx = '0;
        for (int k = 0; k < V; k++) begin
            if (pick[k]) begin
                pick_idx = vc_idx_t'(k);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= vc_idx_t'(V - 1);
        end else if (advance) begin
            ptr <= pick_idx;    // last winner
        end
    end

    a_pick_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(pick));

endmodule

/* src/ovc_credit_counter.sv */
`timescale 1ns/1ps
`include "noc_defs.svh"

module ovc_credit_counter (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                dec,
    input  logic                inc,
    output noc_vc_pkg::credit_t credit
);

    import noc_vc_pkg::*;

    localparam credit_t DEPTH = credit_t'(`NOC_CREDIT_DEPTH);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit <= DEPTH;    // downstream buffer empty
        end else if (dec && !inc) begin
            credit <= credit - credit_t'(1);
        end else if (inc && !dec) begin
            credit <= credit + credit_t'(1);
        end
    end

    // send with nothing left downstream
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        dec && !inc |-> credit != '0);

    // downstream handed back more than it holds
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        inc && !dec |-> credit != DEPTH);

endmodule

/* src/ovc_status.sv */
`timescale 1ns/1ps
`include "noc_defs.svh"

module ovc_status (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 grant_str,
    input  noc_vc_pkg::vc_mask_t grant_vc,
    input  logic                 send_str,
    input  noc_vc_pkg::vc_mask_t send_vc,
    input  logic                 release_str,
    input  noc_vc_pkg::vc_mask_t credit_in,
    output noc_vc_pkg::vc_mask_t free_mask,
    output noc_vc_pkg::vc_mask_t credit_avail
);

    import noc_vc_pkg::*;

    localparam int V = `NOC_V;
    localparam credit_t DEPTH = credit_t'(`NOC_CREDIT_DEPTH);

    vc_mask_t busy;
    vc_mask_t grant_set;
    vc_mask_t release_clr;
    vc_mask_t send_dec;
    credit_t  credit [V];

    assign grant_set = grant_str ? grant_vc : '0;
    assign release_clr = release_str ? send_vc : '0;    // tail leaves on the held vc
    assign send_dec = send_str ? send_vc : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= '0;
        end else begin
            busy <= (busy | grant_set) & ~release_clr;
        end
    end

    for (genvar i = 0; i < V; i++) begin : g_vc
        ovc_credit_counter u_credit (
            .clk    (clk),
            .rst_n  (rst_n),
            .dec    (send_dec[i]),
            .inc    (credit_in[i]),
            .credit (credit[i])
        );

        assign free_mask[i] = !busy[i] && (credit[i] == DEPTH);
        assign credit_avail[i] = (credit[i] != '0);
    end

    // the arbiter only sees free vcs, so a busy target means a broken path
    a_grant_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
        grant_str |-> (grant_vc & busy) == '0);

endmodule

/* src/vc_alloc_fsm.sv */
`timescale 1ns/1ps

module vc_alloc_fsm (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 hdr_valid,
    input  noc_vc_pkg::vc_mask_t pick,
    input  logic                 pick_valid,
    input  noc_vc_pkg::vc_mask_t credit_avail,
    input  logic                 flit_valid,
    input  logic                 flit_tail,
    output logic                 grant_str,
    output logic                 release_str,
    output logic                 send_str,
    output noc_vc_pkg::vc_mask_t cur_vc,
    output logic                 ovc_grant,
    output logic                 flit_ready,
    output logic                 flit_send,
    output noc_vc_pkg::vc_mask_t send_vc
);

    import noc_vc_pkg::*;

    alloc_state_t state;
    alloc_state_t state_nxt;

    assign grant_str = (state == IDLE) && hdr_valid && pick_valid;
    assign flit_ready = (state == ACTIVE) && |(credit_avail & cur_vc);
    assign send_str = (state == ACTIVE) && flit_valid;
    assign release_str = send_str && flit_tail;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (grant_str) begin
                    state_nxt = ACTIVE;
                end
            end
            ACTIVE: begin
                if (release_str) begin
                    state_nxt = IDLE;    // next grant may come right after
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cur_vc <= '0;
            ovc_grant <= 1'b0;
            flit_send <= 1'b0;
            send_vc <= '0;
        end else begin
            ovc_grant <= grant_str;
            flit_send <= send_str;
            send_vc <= send_str ? cur_vc : '0;
            if (grant_str) begin
                cur_vc <= pick;    // held for the whole packet
            end else if (release_str) begin
                cur_vc <= '0;
            end
        end
    end

    // source must respect credit back-pressure
    a_valid_needs_ready: assert property (@(posedge clk) disable iff (!rst_n)
        flit_valid |-> flit_ready);

endmodule

/* src/ovc_alloc_top.sv */
`timescale 1ns/1ps

module ovc_alloc_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 hdr_valid,
    input  noc_flit_pkg::class_t hdr_class,
    input  noc_flit_pkg::dest_t  hdr_dest,
    input  logic                 flit_valid,
    input  logic                 flit_tail,
    input  noc_vc_pkg::vc_mask_t credit_in,
    output logic                 ovc_grant,
    output noc_vc_pkg::vc_mask_t ovc_sel,
    output logic                 flit_ready,
    output logic                 flit_send,
    output noc_vc_pkg::vc_mask_t send_vc
);

    import noc_vc_pkg::*;

    vc_mask_t cand_mask;
    vc_mask_t free_mask;
    vc_mask_t credit_avail;
    vc_mask_t eligible;
    vc_mask_t pick;
    vc_mask_t cur_vc;
    logic     pick_valid;
    logic     grant_str;
    logic     send_str;
    logic     release_str;

    assign eligible = cand_mask & free_mask;    // class allowed and idle with full credit
    assign ovc_sel = cur_vc;

    class_ovc_table u_table (
        .class_in  (hdr_class),
        .cand_mask (cand_mask)
    );

    ovc_arbiter u_arb (
        .clk        (clk),
        .rst_n      (rst_n),
        .eligible   (eligible),
        .dest       (hdr_dest),
        .advance    (grant_str),
        .pick       (pick),
        .pick_valid (pick_valid)
    );

    ovc_status u_status (
        .clk          (clk),
        .rst_n        (rst_n),
        .grant_str    (grant_str),
        .grant_vc     (pick),
        .send_str     (send_str),
        .send_vc      (cur_vc),
        .release_str  (release_str),
        .credit_in    (credit_in),
        .free_mask    (free_mask),
        .credit_avail (credit_avail)
    );

    vc_alloc_fsm u_fsm (
        .clk          (clk),
        .rst_n        (rst_n),
        .hdr_valid    (hdr_valid),
        .pick         (pick),
        .pick_valid   (pick_valid),
        .credit_avail (credit_avail),
        .flit_valid   (flit_valid),
        .flit_tail    (flit_tail),
        .grant_str    (grant_str),
        .release_str  (release_str),
        .send_str     (send_str),
        .cur_vc       (cur_vc),
        .ovc_grant    (ovc_grant),
        .flit_ready   (flit_ready),
        .flit_send    (flit_send),
        .send_vc      (send_vc)
    );

endmodule

/* sim/tb_ovc_alloc.sv */
`timescale 1ns/1ps
`include "noc_defs.svh"

module tb_ovc_alloc;

    import noc_flit_pkg::*;
    import noc_vc_pkg::*;

    localparam int V = `NOC_V;
    localparam int C = `NOC_C;
    localparam int P = `NOC_P;
    localparam int DEPTH = `NOC_CREDIT_DEPTH;
    localparam int NUM_PKTS = 200;
    localparam int GRANT_TIMEOUT = 100;
    localparam int READY_TIMEOUT = 50;
    localparam int DRAIN_TIMEOUT = 40;
    localparam logic [C*V-1:0] CLASS_SETTING = `NOC_CLASS_SETTING;

    logic     clk;
    logic     rst_n;
    logic     hdr_valid;
    class_t   hdr_class;
    dest_t    hdr_dest;
    logic     flit_valid;
    logic     flit_tail;
    vc_mask_t credit_in;
    logic     ovc_grant;
    vc_mask_t ovc_sel;
    logic     flit_ready;
    logic     flit_send;
    vc_mask_t send_vc;

    // reference model state
    vc_mask_t    m_busy;
    int          m_credit [V];
    int          m_ptr;
    logic        m_active;
    vc_mask_t    m_cur;
    class_t      m_class;
    logic        exp_grant;
    logic        exp_ready;
    logic        exp_send;
    vc_mask_t    exp_sel;
    vc_mask_t    exp_send_vc;
    int          cyc;
    int          ret_due [V][DEPTH];    // cycle each credit returns on (-1 marks an empty slot)
    logic [31:0] rng_state;

    ovc_alloc_top UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .hdr_valid  (hdr_valid),
        .hdr_class  (hdr_class),
        .hdr_dest   (hdr_dest),
        .flit_valid (flit_valid),
        .flit_tail  (flit_tail),
        .credit_in  (credit_in),
        .ovc_grant  (ovc_grant),
        .ovc_sel    (ovc_sel),
        .flit_ready (flit_ready),
        .flit_send  (flit_send),
        .send_vc    (send_vc)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'(next_rand() % (hi - lo + 1));
    endfunction

    function automatic dest_t draw_dest();
        if (rand_range(0, 9) == 0) begin
            return '0;    // no port so priority falls to vc 0
        end
        return dest_t'(1) << rand_range(0, P - 2);
    endfunction

    function automatic vc_mask_t class_mask(input class_t c);
        return CLASS_SETTING[int'(c)*V +: V];
    endfunction

    function automatic int onehot_index(input vc_mask_t m);
        int idx;
        idx = 0;
        for (int i = 0; i < V; i++) begin
            if (m[i]) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    // destination preference first, then round-robin after the pointer
    function automatic vc_mask_t expected_pick(input vc_mask_t elig, input dest_t dest,
                                               input int ptr);
        vc_mask_t prio;
        int idx;
        prio = (dest == '0) ? vc_mask_t'(1) : vc_mask_t'(dest);
        if ((elig & prio) != '0) begin
            return elig & prio;
        end
        for (int k = 1; k <= V; k++) begin
            idx = (ptr + k) % V;
            if (elig[idx]) begin
                return vc_mask_t'(1) << idx;
            end
        end
        return '0;
    endfunction

    function automatic logic credits_home();
        logic home;
        home = 1'b1;
        for (int i = 0; i < V; i++) begin
            if (m_credit[i] != DEPTH) begin
                home = 1'b0;
            end
        end
        return home;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (exp === act)
            else fail_run($sformatf("[FAIL] %s: expected 0x%0h, actual 0x%0h", name, exp, act));
    endtask

    always @(posedge clk) begin : model_update
        vc_mask_t elig;
        vc_mask_t pick_m;
        vc_mask_t held;
        logic     grant;
        logic     send;
        logic     rel;
        if (!rst_n) begin
            m_busy = '0;
            for (int i = 0; i < V; i++) begin
                m_credit[i] = DEPTH;
            end
            m_ptr = V - 1;
            m_active = 1'b0;
            m_cur = '0;
            m_class = '0;
            exp_grant = 1'b0;
            exp_ready = 1'b0;
            exp_send = 1'b0;
            exp_sel = '0;
            exp_send_vc = '0;
            cyc = 0;
        end else begin
            cyc++;
            for (int i = 0; i < V; i++) begin
                elig[i] = !m_busy[i] && (m_credit[i] == DEPTH);
            end
            elig = elig & class_mask(hdr_class);
            grant = !m_active && hdr_valid && (elig != '0);
            pick_m = expected_pick(elig, hdr_dest, m_ptr);
            send = m_active && flit_valid;
            rel = send && flit_tail;
            held = m_cur;
            for (int i = 0; i < V; i++) begin
                if (send && held[i] && !credit_in[i]) begin
                    m_credit[i]--;
                end else if (credit_in[i] && !(send && held[i])) begin
                    m_credit[i]++;
                end
            end
            if (grant) begin
                m_busy = m_busy | pick_m;
                m_ptr = onehot_index(pick_m);
                m_active = 1'b1;
                m_cur = pick_m;
                m_class = hdr_class;
            end
            if (rel) begin
                m_busy = m_busy & ~held;
                m_active = 1'b0;
                m_cur = '0;
            end
            exp_grant = grant;
            exp_sel = m_cur;
            exp_send = send;
            exp_send_vc = send ? held : '0;
            exp_ready = m_active && (m_credit[onehot_index(m_cur)] > 0);
        end
    end

    always @(negedge clk) begin : compare
        if (rst_n) begin
            check_value("grant pulse", 32'(exp_grant), 32'(ovc_grant));
            check_value("ovc_sel", 32'(exp_sel), 32'(ovc_sel));
            check_value("flit_ready", 32'(exp_ready), 32'(flit_ready));
            check_value("flit_send", 32'(exp_send), 32'(flit_send));
            check_value("send_vc", 32'(exp_send_vc), 32'(send_vc));
            if (ovc_grant) begin
                check_value("class restriction", 32'd0,
                            32'(ovc_sel & ~class_mask(m_class)));
            end
            if (flit_send && ovc_sel != '0) begin
                check_value("send_vc against ovc_sel", 32'(ovc_sel), 32'(send_vc));
            end
        end
    end

    // downstream sink frees each slot a few cycles after the flit lands
    always @(negedge clk) begin : downstream_sink
        int   vc;
        logic placed;
        if (rst_n && flit_send) begin
            vc = onehot_index(send_vc);
            placed = 1'b0;
            for (int s = 0; s < DEPTH; s++) begin
                if (!placed && ret_due[vc][s] < 0) begin
                    ret_due[vc][s] = cyc + rand_range(1, 8);
                    placed = 1'b1;
                end
            end
            if (!placed) begin
                fail_run("more flits in flight on one vc than the downstream buffer holds");
            end
        end
    end

    always @(posedge clk) begin : credit_return
        logic sent;
        #1;
        credit_in = '0;
        if (rst_n) begin
            for (int v = 0; v < V; v++) begin
                sent = 1'b0;
                for (int s = 0; s < DEPTH; s++) begin
                    if (!sent && ret_due[v][s] >= 0 && ret_due[v][s] <= cyc) begin
                        credit_in[v] = 1'b1;    // one pulse per vc per cycle
                        ret_due[v][s] = -1;
                        sent = 1'b1;
                    end
                end
            end
        end
    end

    initial begin : stimulus
        int len;
        int gap;
        int waited;
        clk = 1'b0;
        rst_n = 1'b0;
        hdr_valid = 1'b0;
        hdr_class = '0;
        hdr_dest = '0;
        flit_valid = 1'b0;
        flit_tail = 1'b0;
        credit_in = '0;
        rng_state = 32'd96720;
        for (int v = 0; v < V; v++) begin
            for (int s = 0; s < DEPTH; s++) begin
                ret_due[v][s] = -1;
            end
        end

        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_value("reset ovc_grant", 32'd0, 32'(ovc_grant));
        check_value("reset flit_send", 32'd0, 32'(flit_send));
        check_value("reset flit_ready", 32'd0, 32'(flit_ready));
        check_value("reset ovc_sel", 32'd0, 32'(ovc_sel));
        @(posedge clk);
        #1;

        for (int n = 0; n < NUM_PKTS; n++) begin
            hdr_class = class_t'(rand_range(0, C - 1));
            hdr_dest = draw_dest();
            hdr_valid = 1'b1;
            waited = 0;
            do begin
                @(posedge clk);
                #1;
                waited++;
            end while (!ovc_grant && waited < GRANT_TIMEOUT);
            if (!ovc_grant) begin
                fail_run($sformatf("timeout: packet %0d got no grant within %0d cycles",
                                   n, GRANT_TIMEOUT));
            end
            hdr_valid = 1'b0;
            len = rand_range(1, 6);
            for (int f = 0; f < len; f++) begin
                gap = rand_range(0, 2);
                repeat (gap) begin
                    @(posedge clk);
                    #1;
                end
                waited = 0;
                while (!flit_ready && waited < READY_TIMEOUT) begin
                    @(posedge clk);
                    #1;
                    waited++;
                end
                if (!flit_ready) begin
                    fail_run($sformatf("timeout: packet %0d flit %0d never saw flit_ready",
                                       n, f));
                end
                flit_valid = 1'b1;
                flit_tail = (f == len - 1);
                @(posedge clk);
                #1;
                flit_valid = 1'b0;
                flit_tail = 1'b0;
            end
        end

        waited = 0;
        while (!credits_home() && waited < DRAIN_TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!credits_home()) begin
            fail_run("timeout: downstream credits did not all return after the last packet");
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* list.f */
+incdir+src
src/noc_flit_pkg.sv
src/noc_vc_pkg.sv
src/class_ovc_table.sv
src/ovc_arbiter.sv
src/ovc_credit_counter.sv
src/ovc_status.sv
src/vc_alloc_fsm.sv
src/ovc_alloc_top.sv
sim/tb_ovc_alloc.sv

/* Makefile */
TB_TOP := tb_ovc_alloc

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f list.f --top-module ovc_alloc_top

obj_dir/V$(TB_TOP): list.f src/*.sv src/*.svh sim/*.sv
	verilator --binary --timing --assert -Wno-fatal -f list.f \
		--top-module $(TB_TOP) -o V$(TB_TOP)

sim: obj_dir/V$(TB_TOP)
	./obj_dir/V$(TB_TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then exit 1; fi
	@grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
